/* bench/regex_tests.txt */
# P <word address hex> <data hex>              memory preload
# R <test name> <string word address hex> <accept|reject|error>
P 100 6261
P 101 0000
P 102 7861
P 103 0000
P 104 0061
P 105 6261
P 106 0064
P 107 6361
P 108 0064
P 109 0062
P 000 0061
P 001 0062
P 002 4000
R ab 100 accept
R ax 102 reject
R a 104 reject
P 000 0061
P 001 c100
P 002 0062
P 003 8140
P 004 0063
P 005 0064
P 006 4000
R abd 105 accept
R acd 107 accept
R ab_no_d 100 reject
P 000 c280
P 001 c280
P 002 c280
P 003 c280
P 004 c280
P 005 007a
P 00a 0061
R overflow 104 error
R after_reset 109 reject

/* tb.f */
src/regex_pkg.sv
src/regex_ifs.sv
src/regex_mem_arbiter.sv
src/regex_controller.sv
src/regex_thread_engine.sv
src/regex_coprocessor.sv
bench/regex_checker.sv
bench/regex_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = regex_tb
FILELIST  = tb.f
BUILD_DIR = obj_dir
PASS_MSG  = Result: PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/regex_tb.sv */
`default_nettype none

module regex_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import regex_pkg::*;

    localparam int RESET_CYCLES = 4;
    // upper bound for any single wait in clock cycles
    localparam int WAIT_LIMIT = 2000;

    logic                      clk;
    logic                      reset;
    logic                      memory_ready;
    logic [MEM_ADDR_WIDTH-1:0] memory_addr;
    logic [MEM_DATA_WIDTH-1:0] memory_data;
    logic                      memory_valid;
    logic                      start_ready;
    logic [MEM_ADDR_WIDTH-1:0] start_cc_pointer;
    logic                      start_valid;
    logic                      finish;
    logic                      accept;
    logic                      error;

    // shared memory model
    logic [MEM_DATA_WIDTH-1:0] mem [2**MEM_ADDR_WIDTH];
    logic                      grant_seen;
    logic [MEM_ADDR_WIDTH-1:0] grant_addr;
    logic                      backpressure;
    logic [31:0]               lfsr;

    // pulses seen during the current run
    int   start_count;
    int   finish_count;
    int   accept_count;
    int   tests_run;
    int   tests_failed;
    int   pass_index;
    logic test_failed;

    regex_coprocessor u_dut (
        .clk              (clk),
        .reset            (reset),
        .memory_ready     (memory_ready),
        .memory_addr      (memory_addr),
        .memory_data      (memory_data),
        .memory_valid     (memory_valid),
        .start_ready      (start_ready),
        .start_cc_pointer (start_cc_pointer),
        .start_valid      (start_valid),
        .finish           (finish),
        .accept           (accept),
        .error            (error)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // outcome word from the data file as 0 for accept, 1 for reject and 2 for error
    function automatic int outcome_code(input logic [127:0] word);
        if (word == 128'("accept"))
            return 0;
        if (word == 128'("reject"))
            return 1;
        if (word == 128'("error"))
            return 2;
        return -1;
    endfunction

    // memory answers one cycle after each grant
    initial
    begin
        memory_ready = 1'b1;
        memory_data  = '0;
        forever
        begin
            // grant is stable by the falling edge
            @(negedge clk);
            grant_seen = memory_valid && memory_ready;
            grant_addr = memory_addr;
            @(posedge clk);
            #1;
            memory_data = grant_seen ? mem[grant_addr] : '0;
            if (backpressure)
            begin
                lfsr         = lfsr_step(lfsr);
                memory_ready = lfsr[0];
            end
            else
                memory_ready = 1'b1;
        end
    end

    always @(negedge clk)
    begin
        if (start_valid)
            start_count++;
        if (finish)
            finish_count++;
        if (accept)
            accept_count++;
    end

    task automatic apply_reset();
        @(posedge clk);
        #1;
        reset       = 1'b1;
        start_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got == expected)
        else
        begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", what, got, expected);
            test_failed = 1'b1;
        end
    endtask

    task automatic run_match(input logic [127:0] name, input logic [MEM_ADDR_WIDTH-1:0] addr,
                             input int expected);
        int   cycles;
        logic started;
        logic ended;
        logic accept_seen;
        test_failed = 1'b0;
        started     = 1'b0;
        ended       = 1'b0;
        accept_seen = 1'b0;
        // no memory request while the coprocessor sits idle
        @(negedge clk);
        check_value("memory_valid", {31'b0, memory_valid}, 32'd0);
        @(posedge clk);
        #1;
        start_count      = 0;
        finish_count     = 0;
        accept_count     = 0;
        start_cc_pointer = addr;
        start_ready      = 1'b1;
        // host request held until the first word is granted
        cycles = 0;
        while (!started && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            started = start_valid;
            cycles++;
        end
        // first request goes to the string word
        if (started)
            check_value("memory_addr", 32'(memory_addr), 32'(addr));
        @(posedge clk);
        #1;
        start_ready = 1'b0;
        if (!started)
        begin
            $display("test %0s: the start request was never accepted", name);
            test_failed = 1'b1;
        end
        else
        begin
            cycles = 0;
            while (!ended && cycles < WAIT_LIMIT)
            begin
                @(negedge clk);
                ended       = finish || error;
                accept_seen = accept;
                cycles++;
            end
            if (!ended)
            begin
                $display("test %0s: timed out waiting for finish or error", name);
                test_failed = 1'b1;
            end
            else
            begin
                // a few idle cycles to catch repeated pulses or a dropped error
                repeat (3) @(negedge clk);
                check_value("error", {31'b0, error}, (expected == 2) ? 32'd1 : 32'd0);
                check_value("accept", {31'b0, accept_seen}, (expected == 0) ? 32'd1 : 32'd0);
                check_value("finish pulses", finish_count, (expected == 2) ? 32'd0 : 32'd1);
                check_value("accept pulses", accept_count, (expected == 0) ? 32'd1 : 32'd0);
                check_value("start_valid pulses", start_count, 32'd1);
            end
        end
        if (expected == 2 || !ended)
            apply_reset();
        tests_run++;
        if (test_failed)
            tests_failed++;
        $display("pass %0d test %0s: %s", pass_index, name, test_failed ? "failed" : "ok");
    endtask

    // P records preload memory and R records run one match
    task automatic run_test_file();
        int                        fd;
        int                        n;
        int                        code;
        string                     line;
        byte                       kind;
        logic [MEM_ADDR_WIDTH-1:0] addr;
        logic [MEM_DATA_WIDTH-1:0] word;
        logic [127:0]              name;
        logic [127:0]              outcome;
        fd = $fopen("bench/regex_tests.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open bench/regex_tests.txt");
            tests_failed++;
            return;
        end
        while (!$feof(fd))
        begin
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0)
            begin
                kind = line[0];
                if (kind == "P")
                begin
                    n = $sscanf(line, "P %h %h", addr, word);
                    if (n == 2)
                        mem[addr] = word;
                    else
                    begin
                        $display("malformed preload record in the test file");
                        tests_failed++;
                    end
                end
                else if (kind == "R")
                begin
                    n    = $sscanf(line, "R %s %h %s", name, addr, outcome);
                    code = outcome_code(outcome);
                    if (n == 3 && code >= 0)
                        run_match(name, addr, code);
                    else
                    begin
                        $display("malformed run record in the test file");
                        tests_failed++;
                    end
                end
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        reset            = 1'b1;
        start_ready      = 1'b0;
        start_cc_pointer = '0;
        backpressure     = 1'b0;
        lfsr             = 32'hb789_93b4;
        tests_run        = 0;
        tests_failed     = 0;
        pass_index       = 1;
        // fill pattern carries every address bit
        for (int i = 0; i < 2**MEM_ADDR_WIDTH; i++)
            mem[i] = 16'(i) ^ 16'hc3a5;
        apply_reset();
        run_test_file();
        // same runs again with random memory_ready
        pass_index   = 2;
        backpressure = 1'b1;
        run_test_file();
        $display("tests run %0d, failed %0d", tests_run, tests_failed);
        if (tests_failed == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/regex_checker.sv */
`default_nettype none

module regex_checker
(
    input logic clk,
    input logic reset,
    input logic finish,
    input logic accept,
    input logic error
);
    timeunit 1ns;
    timeprecision 1ps;

    // a run ends either normally or in error, never both
    assert property (@(posedge clk) disable iff (reset) !(finish && error))
    else $error("finish and error are high in the same cycle");

    assert property (@(posedge clk) disable iff (reset) accept |-> finish)
    else $error("accept is high without finish");

    // error is sticky until reset
    assert property (@(posedge clk) disable iff (reset) error |=> error)
    else $error("error dropped without a reset");

endmodule

bind regex_coprocessor regex_checker u_checker (
    .clk    (clk),
    .reset  (reset),
    .finish (finish),
    .accept (accept),
    .error  (error)
);

`default_nettype wire

/* src/regex_coprocessor.sv */
`default_nettype none

module regex_coprocessor
(
    input  logic                                  clk,
    input  logic                                  reset,

    // shared memory
    input  logic                                  memory_ready,
    output logic [regex_pkg::MEM_ADDR_WIDTH-1:0]  memory_addr,
    input  logic [regex_pkg::MEM_DATA_WIDTH-1:0]  memory_data,
    output logic                                  memory_valid,

    // host side
    input  logic                                  start_ready,
    input  logic [regex_pkg::MEM_ADDR_WIDTH-1:0]  start_cc_pointer,
    output logic                                  start_valid,
    output logic                                  finish,
    output logic                                  accept,
    output logic                                  error
);
    // controller and engine memory ports, controller side has priority
    regex_mem_if  char_mem ();
    regex_mem_if  instr_mem ();
    regex_step_if step ();

    regex_mem_arbiter u_arbiter (
        .clk          (clk),
        .reset        (reset),
        .char_mem     (char_mem),
        .instr_mem    (instr_mem),
        .memory_ready (memory_ready),
        .memory_addr  (memory_addr),
        .memory_valid (memory_valid),
        .memory_data  (memory_data)
    );

    regex_controller u_controller (
        .clk              (clk),
        .reset            (reset),
        .start_ready      (start_ready),
        .start_cc_pointer (start_cc_pointer),
        .start_valid      (start_valid),
        .finish           (finish),
        .accept           (accept),
        .error            (error),
        .char_mem         (char_mem),
        .step             (step)
    );

    regex_thread_engine u_engine (
        .clk       (clk),
        .reset     (reset),
        .step      (step),
        .instr_mem (instr_mem)
    );

endmodule

`default_nettype wire

/* src/regex_thread_engine.sv */
`default_nettype none

module regex_thread_engine
(
    input  logic           clk,
    input  logic           reset,
    regex_step_if.engine   step,
    regex_mem_if.requester instr_mem
);
    import regex_pkg::*;

    // one pc queue per character parity
    logic [PC_WIDTH-1:0]        queue_mem [2][QUEUE_DEPTH];
    logic [QUEUE_DEPTH_LOG-1:0] rd_ptr [2];
    logic [QUEUE_DEPTH_LOG-1:0] wr_ptr [2];
    logic [QUEUE_DEPTH_LOG:0]   count [2];

    // pushes and pops requested this cycle, per queue
    logic [QUEUE_DEPTH_LOG:0]   push_n [2];
    logic [PC_WIDTH-1:0]        push_pc0 [2];
    logic [PC_WIDTH-1:0]        push_pc1 [2];
    logic                       push_ok [2];
    logic                       pop [2];
    logic                       push_lost;
    logic                       accept_hit;

    logic                       cur_q;
    logic                       nxt_q;
    logic                       issue;
    logic                       in_flight;
    logic [PC_WIDTH-1:0]        flight_pc;
    logic [PC_WIDTH-1:0]        next_pc;
    logic [PC_WIDTH-1:0]        head_pc;
    regex_instr_t               instr;

    assign cur_q   = step.even_char;
    assign nxt_q   = ~step.even_char;
    assign head_pc = queue_mem[cur_q][rd_ptr[cur_q]];
    assign next_pc = flight_pc + 1'b1;
    // word returned for the instruction in flight
    assign instr   = instr_mem.data;

    // request held until granted, pop happens on the grant
    assign instr_mem.valid = step.go && !in_flight && (count[cur_q] != '0);
    assign instr_mem.addr  = {{(MEM_ADDR_WIDTH-PC_WIDTH){1'b0}}, head_pc};
    assign issue           = instr_mem.valid && instr_mem.ready;

    assign step.running = in_flight || (count[cur_q] != '0);

    always_comb
    begin
        for (int q = 0; q < 2; q++)
        begin
            push_n[q]   = '0;
            push_pc0[q] = START_PC;
            push_pc1[q] = START_PC;
        end
        accept_hit = 1'b0;
        // first thread of the run
        if (step.seed)
            push_n[cur_q] = 1;
        // execute in the cycle the word comes back
        if (in_flight)
        begin
            case (instr.char_view.opcode)
                OP_MATCH:
                begin
                    // survivor moves on to the next character
                    if (instr.char_view.char_value == step.current_char)
                    begin
                        push_n[nxt_q]   = 1;
                        push_pc0[nxt_q] = next_pc;
                    end
                end
                OP_ACCEPT:
                    accept_hit = 1'b1;
                OP_JMP:
                begin
                    push_n[cur_q]   = 1;
                    push_pc0[cur_q] = instr.branch_view.target;
                end
                OP_SPLIT:
                begin
                    // both branches stay on this character
                    push_n[cur_q]   = 2;
                    push_pc0[cur_q] = instr.branch_view.target;
                    push_pc1[cur_q] = next_pc;
                end
            endcase
        end
        push_lost = 1'b0;
        for (int q = 0; q < 2; q++)
        begin
            push_ok[q] = (push_n[q] != '0) && (count[q] + push_n[q] <= QUEUE_DEPTH);
            pop[q]     = issue && (cur_q == q[0]);
            // a thread would be dropped
            if (push_n[q] != '0 && !push_ok[q])
                push_lost = 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset || step.flush)
        begin
            for (int q = 0; q < 2; q++)
            begin
                rd_ptr[q] <= '0;
                wr_ptr[q] <= '0;
                count[q]  <= '0;
            end
            in_flight     <= 1'b0;
            step.accepts  <= 1'b0;
            step.overflow <= 1'b0;
        end
        else
        begin
            for (int q = 0; q < 2; q++)
            begin
                if (push_ok[q])
                    wr_ptr[q] <= wr_ptr[q] + push_n[q][QUEUE_DEPTH_LOG-1:0];
                if (pop[q])
                    rd_ptr[q] <= rd_ptr[q] + 1'b1;
                count[q] <= count[q] + (push_ok[q] ? push_n[q] : '0)
                            - {{QUEUE_DEPTH_LOG{1'b0}}, pop[q]};
            end
            // data always returns one cycle after the grant
            in_flight <= issue;
            if (accept_hit)
                step.accepts <= 1'b1;
            if (push_lost)
                step.overflow <= 1'b1;
        end
    end

    // queue storage and pc of the instruction in flight
    always_ff @(posedge clk)
    begin
        if (issue)
            flight_pc <= head_pc;
        for (int q = 0; q < 2; q++)
        begin
            if (push_ok[q])
            begin
                queue_mem[q][wr_ptr[q]] <= push_pc0[q];
                if (push_n[q] == 2)
                    queue_mem[q][wr_ptr[q] + 1'b1] <= push_pc1[q];
            end
        end
    end

endmodule

`default_nettype wire

/* src/regex_controller.sv */
`default_nettype none

module regex_controller
(
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  start_ready,
    input  logic [regex_pkg::MEM_ADDR_WIDTH-1:0]  start_cc_pointer,
    output logic                                  start_valid,
    output logic                                  finish,
    output logic                                  accept,
    output logic                                  error,
    regex_mem_if.requester                        char_mem,
    regex_step_if.controller                      step
);
    import regex_pkg::*;

    regex_state_t            state;
    regex_state_t            next_state;
    // byte pointer, low bit picks the byte inside a word
    logic [MEM_ADDR_WIDTH:0] cc_pointer;
    logic [MEM_ADDR_WIDTH:0] next_cc_pointer;
    logic [MEM_ADDR_WIDTH:0] advance_pointer;
    logic [CHAR_WIDTH-1:0]   cur_char;
    logic [CHAR_WIDTH-1:0]   next_char;
    logic [CHAR_WIDTH-1:0]   fetched_char;
    logic                    even_char;
    logic                    next_even_char;

    assign advance_pointer = cc_pointer + 1'b1;
    // low byte for even pointer, high byte for odd
    assign fetched_char = cc_pointer[0] ? char_mem.data[CHAR_WIDTH +: CHAR_WIDTH]
                                        : char_mem.data[0 +: CHAR_WIDTH];

    assign step.current_char = cur_char;
    assign step.even_char    = even_char;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= IDLE;
            cc_pointer <= '0;
            cur_char   <= '0;
            even_char  <= 1'b1;
        end
        else
        begin
            state      <= next_state;
            cc_pointer <= next_cc_pointer;
            cur_char   <= next_char;
            even_char  <= next_even_char;
        end
    end

    always_comb
    begin
        next_state      = state;
        next_cc_pointer = cc_pointer;
        next_char       = cur_char;
        next_even_char  = even_char;
        start_valid     = 1'b0;
        finish          = 1'b0;
        accept          = 1'b0;
        error           = 1'b0;
        char_mem.valid  = 1'b0;
        char_mem.addr   = start_cc_pointer;
        step.go         = 1'b0;
        step.seed       = 1'b0;
        step.flush      = 1'b0;
        case (state)
            IDLE:
            begin
                // first string word, only while the host offers a job
                char_mem.valid = start_ready;
                if (start_ready && char_mem.ready)
                begin
                    next_state      = FETCH_FIRST;
                    next_cc_pointer = {start_cc_pointer, 1'b0};
                    start_valid     = 1'b1;
                end
            end
            FETCH_FIRST:
            begin
                // word is back, start the first thread
                next_char  = fetched_char;
                step.seed  = 1'b1;
                next_state = EXEC;
            end
            EXEC:
            begin
                step.go = 1'b1;
                if (step.overflow)
                    next_state = ERROR;
                else if (step.accepts)
                    next_state = DONE_ACCEPT;
                else if (!step.running)
                begin
                    // all threads for this character are done
                    if (cur_char == CHAR_TERMINATOR)
                        next_state = DONE_REJECT;
                    else
                    begin
                        char_mem.valid = 1'b1;
                        char_mem.addr  = advance_pointer[MEM_ADDR_WIDTH:1];
                        if (char_mem.ready)
                        begin
                            next_state      = FETCH_NEXT;
                            next_cc_pointer = advance_pointer;
                            // next queue becomes current
                            next_even_char  = ~even_char;
                        end
                    end
                end
            end
            FETCH_NEXT:
            begin
                next_char = fetched_char;
                // no surviving thread means no match
                next_state = step.running ? EXEC : DONE_REJECT;
            end
            DONE_ACCEPT:
            begin
                finish     = 1'b1;
                accept     = 1'b1;
                step.flush = 1'b1;
                next_state = IDLE;
            end
            DONE_REJECT:
            begin
                finish     = 1'b1;
                step.flush = 1'b1;
                next_state = IDLE;
            end
            ERROR:
            begin
                // held until reset
                error = 1'b1;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/regex_mem_arbiter.sv */
`default_nettype none

module regex_mem_arbiter
(
    input  logic                                  clk,
    input  logic                                  reset,
    regex_mem_if.arbiter                          char_mem,
    regex_mem_if.arbiter                          instr_mem,
    input  logic                                  memory_ready,
    output logic [regex_pkg::MEM_ADDR_WIDTH-1:0]  memory_addr,
    output logic                                  memory_valid,
    input  logic [regex_pkg::MEM_DATA_WIDTH-1:0]  memory_data
);
    // character fetch always wins over instruction fetch
    logic char_selected;
    // a word comes back this cycle
    logic resp_pending;
    // and it belongs to the character side
    logic resp_to_char;

    assign char_selected = char_mem.valid;

    assign memory_valid = char_mem.valid | instr_mem.valid;
    assign memory_addr  = char_selected ? char_mem.addr : instr_mem.addr;

    // only the selected side sees ready
    assign char_mem.ready  = memory_ready & char_selected;
    assign instr_mem.ready = memory_ready & ~char_selected;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            resp_pending <= 1'b0;
            resp_to_char <= 1'b0;
        end
        else
        begin
            resp_pending <= memory_valid & memory_ready;
            resp_to_char <= char_selected;
        end
    end

    // steer returned word to its owner, the other side reads zero
    assign char_mem.data  = (resp_pending && resp_to_char) ? memory_data : '0;
    assign instr_mem.data = (resp_pending && !resp_to_char) ? memory_data : '0;

endmodule

`default_nettype wire

/* src/regex_ifs.sv */
`default_nettype none

// valid/ready memory request, data follows a grant by one cycle
interface regex_mem_if;
    import regex_pkg::*;

    logic                       valid;
    logic                       ready;
    logic [MEM_ADDR_WIDTH-1:0]  addr;
    // zero except in the cycle after this requester was granted
    logic [MEM_DATA_WIDTH-1:0]  data;

    modport requester (output valid, output addr, input ready, input data);
    modport arbiter (input valid, input addr, output ready, output data);
endinterface

// per-character control between run FSM and thread engine
interface regex_step_if;
    import regex_pkg::*;

    logic                   go;
    // single-cycle pulses
    logic                   seed;
    logic                   flush;
    logic [CHAR_WIDTH-1:0]  current_char;
    // selects which pc queue is current
    logic                   even_char;
    logic                   running;
    logic                   accepts;
    logic                   overflow;

    modport controller (
        output go, output seed, output flush, output current_char, output even_char,
        input running, input accepts, input overflow
    );
    modport engine (
        input go, input seed, input flush, input current_char, input even_char,
        output running, output accepts, output overflow
    );
endinterface

`default_nettype wire

/* src/regex_pkg.sv */
`default_nettype none

package regex_pkg;

    // shared memory geometry
    localparam int MEM_ADDR_WIDTH = 11;
    localparam int MEM_DATA_WIDTH = 16;
    // two characters per memory word, low byte first
    localparam int CHAR_WIDTH = 8;
    // program counter p is memory word p
    localparam int PC_WIDTH = 8;

    // each pc queue holds 2**QUEUE_DEPTH_LOG entries
    localparam int QUEUE_DEPTH_LOG = 2;
    localparam logic [QUEUE_DEPTH_LOG:0] QUEUE_DEPTH = {1'b1, {QUEUE_DEPTH_LOG{1'b0}}};

    // zero byte closes the string
    localparam logic [CHAR_WIDTH-1:0] CHAR_TERMINATOR = '0;
    // first thread of a run starts here
    localparam logic [PC_WIDTH-1:0] START_PC = '0;

    typedef enum logic [1:0] {
        OP_MATCH  = 2'd0,
        OP_ACCEPT = 2'd1,
        OP_JMP    = 2'd2,
        OP_SPLIT  = 2'd3
    } regex_opcode_t;

    // used by MATCH
    typedef struct packed {
        regex_opcode_t           opcode;
        logic [5:0]              reserved;
        logic [CHAR_WIDTH-1:0]   char_value;
    } regex_char_view_t;

    // used by JMP and SPLIT
    typedef struct packed {
        regex_opcode_t           opcode;
        logic [PC_WIDTH-1:0]     target;
        logic [5:0]              reserved;
    } regex_branch_view_t;

    // one instruction word, opcode sits in the same place in both views
    typedef union packed {
        regex_char_view_t   char_view;
        regex_branch_view_t branch_view;
    } regex_instr_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH_FIRST,
        FETCH_NEXT,
        EXEC,
        DONE_ACCEPT,
        DONE_REJECT,
        ERROR
    } regex_state_t;

endpackage

`default_nettype wire
